//--- cpu_subsystem_pkg.sv
`default_nettype none

package cpu_subsystem_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////////////////////

	localparam int cpu_addr_w = 16;
	localparam int bus_addr_w = 13;
	localparam int data_w = 8;

	// Target region of a CPU write
	typedef enum logic [3:0] {
		region_none      = 4'd0,
		region_scroll0   = 4'd1,
		region_scroll1   = 4'd2,
		region_object    = 4'd3,
		region_latch0    = 4'd4,
		region_latch1    = 4'd5,
		region_backcolor = 4'd6,
		region_bank      = 4'd7,
		region_irq_ack   = 4'd8
	} region_t;

	////////////////////////////////////////////////////////////////////////////
	// Master map, pages on A[15:11]
	////////////////////////////////////////////////////////////////////////////

	localparam logic [4:0] master_page_scroll0 = 5'h04;
	localparam logic [4:0] master_page_scroll1 = 5'h05;
	localparam logic [4:0] master_page_object = 5'h06;
	localparam logic [4:0] master_page_latch0 = 5'h08;
	localparam logic [4:0] master_page_latch1 = 5'h09;
	localparam logic [4:0] master_page_irq_ack = 5'h10;

	////////////////////////////////////////////////////////////////////////////
	// Sub map, pages on A[15:10]
	////////////////////////////////////////////////////////////////////////////

	localparam logic [5:0] sub_page_scroll0 = 6'h08;
	localparam logic [5:0] sub_page_scroll1 = 6'h0a;
	localparam logic [5:0] sub_page_object = 6'h0c;
	localparam logic [5:0] sub_page_backcolor = 6'h10;
	localparam logic [5:0] sub_page_bank = 6'h11;
	localparam logic [5:0] sub_page_irq_ack = 6'h12;

	// Latch contents after reset
	localparam logic [data_w-1:0] latch_reset = 8'h00;
	localparam logic bank_reset = 1'b0;

endpackage

`default_nettype wire

//--- master_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module master_decoder (
	input  wire                                            clk_6m,
	input  wire                                            reset,
	input  wire [cpu_subsystem_pkg::cpu_addr_w-1:0]        addr,
	input  wire [cpu_subsystem_pkg::data_w-1:0]            wdata,
	input  wire                                            wr,
	input  wire                                            vblank_n,
	output logic                                           req,
	output cpu_subsystem_pkg::region_t                     req_region,
	output logic [cpu_subsystem_pkg::bus_addr_w-1:0]       req_addr,
	output logic [cpu_subsystem_pkg::data_w-1:0]           req_data,
	output logic                                           irq_n
);

	cpu_subsystem_pkg::region_t page_region;
	logic vblank_d;
	logic vblank_fall;
	logic irq_flag;
	logic irq_ack_wr;

	////////////////////////////////////////////////////////////////////////////
	// Page lookup on A[15:11]
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (addr[15:11])
			cpu_subsystem_pkg::master_page_scroll0: page_region = cpu_subsystem_pkg::region_scroll0;
			cpu_subsystem_pkg::master_page_scroll1: page_region = cpu_subsystem_pkg::region_scroll1;
			cpu_subsystem_pkg::master_page_object: page_region = cpu_subsystem_pkg::region_object;
			cpu_subsystem_pkg::master_page_latch0: page_region = cpu_subsystem_pkg::region_latch0;
			cpu_subsystem_pkg::master_page_latch1: page_region = cpu_subsystem_pkg::region_latch1;
			cpu_subsystem_pkg::master_page_irq_ack: page_region = cpu_subsystem_pkg::region_irq_ack;
			default: page_region = cpu_subsystem_pkg::region_none;
		endcase
	end

	// Only real bus regions go out as requests
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			req <= 1'b0;
		end else begin
			req <= wr && (page_region != cpu_subsystem_pkg::region_none)
				&& (page_region != cpu_subsystem_pkg::region_irq_ack);
		end
	end

	// Payload of the request
	always_ff @(posedge clk_6m) begin
		if (wr) begin
			req_region <= page_region;
			req_addr <= addr[cpu_subsystem_pkg::bus_addr_w-1:0];
			req_data <= wdata;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Vertical blank interrupt
	////////////////////////////////////////////////////////////////////////////

	assign vblank_fall = vblank_d && !vblank_n;
	assign irq_ack_wr = wr && (page_region == cpu_subsystem_pkg::region_irq_ack);

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			vblank_d <= 1'b1;
			irq_flag <= 1'b0;
		end else begin
			vblank_d <= vblank_n;
			// New edge wins over an ack in the same cycle
			if (vblank_fall) begin
				irq_flag <= 1'b1;
			end else if (irq_ack_wr) begin
				irq_flag <= 1'b0;
			end
		end
	end

	assign irq_n = ~irq_flag;

endmodule

`default_nettype wire

//--- sub_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module sub_decoder (
	input  wire                                            clk_6m,
	input  wire                                            reset,
	input  wire [cpu_subsystem_pkg::cpu_addr_w-1:0]        addr,
	input  wire [cpu_subsystem_pkg::data_w-1:0]            wdata,
	input  wire                                            wr,
	input  wire                                            vblank_n,
	output logic                                           req,
	output cpu_subsystem_pkg::region_t                     req_region,
	output logic [cpu_subsystem_pkg::bus_addr_w-1:0]       req_addr,
	output logic [cpu_subsystem_pkg::data_w-1:0]           req_data,
	output logic                                           irq_n
);

	cpu_subsystem_pkg::region_t page_region;
	logic vblank_d;
	logic vblank_fall;
	logic irq_flag;
	logic irq_ack_wr;

	////////////////////////////////////////////////////////////////////////////
	// Page lookup on A[15:10]
	////////////////////////////////////////////////////////////////////////////

	// Backcolor and bank only exist in this map
	always_comb begin
		case (addr[15:10])
			cpu_subsystem_pkg::sub_page_scroll0: page_region = cpu_subsystem_pkg::region_scroll0;
			cpu_subsystem_pkg::sub_page_scroll1: page_region = cpu_subsystem_pkg::region_scroll1;
			cpu_subsystem_pkg::sub_page_object: page_region = cpu_subsystem_pkg::region_object;
			cpu_subsystem_pkg::sub_page_backcolor:
				page_region = cpu_subsystem_pkg::region_backcolor;
			cpu_subsystem_pkg::sub_page_bank: page_region = cpu_subsystem_pkg::region_bank;
			cpu_subsystem_pkg::sub_page_irq_ack: page_region = cpu_subsystem_pkg::region_irq_ack;
			default: page_region = cpu_subsystem_pkg::region_none;
		endcase
	end

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			req <= 1'b0;
		end else begin
			req <= wr && (page_region != cpu_subsystem_pkg::region_none)
				&& (page_region != cpu_subsystem_pkg::region_irq_ack);
		end
	end

	always_ff @(posedge clk_6m) begin
		if (wr) begin
			req_region <= page_region;
			req_addr <= addr[cpu_subsystem_pkg::bus_addr_w-1:0];
			req_data <= wdata;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Vertical blank interrupt
	////////////////////////////////////////////////////////////////////////////

	assign vblank_fall = vblank_d && !vblank_n;
	assign irq_ack_wr = wr && (page_region == cpu_subsystem_pkg::region_irq_ack);

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			vblank_d <= 1'b1;
			irq_flag <= 1'b0;
		end else begin
			vblank_d <= vblank_n;
			if (vblank_fall) begin
				irq_flag <= 1'b1;
			end else if (irq_ack_wr) begin
				irq_flag <= 1'b0;
			end
		end
	end

	// Active low toward the sub CPU
	assign irq_n = ~irq_flag;

endmodule

`default_nettype wire

//--- bus_mux.sv
`timescale 1ns/1ps
`default_nettype none

module bus_mux (
	input  wire                                            clk_6m,
	input  wire                                            reset,
	input  wire                                            m_req,
	input  wire cpu_subsystem_pkg::region_t                m_region,
	input  wire [cpu_subsystem_pkg::bus_addr_w-1:0]        m_addr,
	input  wire [cpu_subsystem_pkg::data_w-1:0]            m_data,
	input  wire                                            s_req,
	input  wire cpu_subsystem_pkg::region_t                s_region,
	input  wire [cpu_subsystem_pkg::bus_addr_w-1:0]        s_addr,
	input  wire [cpu_subsystem_pkg::data_w-1:0]            s_data,
	output logic                                           bus_we,
	output cpu_subsystem_pkg::region_t                     bus_region,
	output logic [cpu_subsystem_pkg::bus_addr_w-1:0]       bus_addr,
	output logic [cpu_subsystem_pkg::data_w-1:0]           bus_data,
	output logic                                           bus_from_sub,
	output logic                                           overrun
);

	// Phase 0 is the master slot, phase 1 the sub slot
	logic phase;

	logic m_full;
	logic s_full;
	logic m_issue;
	logic s_issue;
	logic m_accept;
	logic s_accept;

	cpu_subsystem_pkg::region_t m_slot_region;
	cpu_subsystem_pkg::region_t s_slot_region;
	logic [cpu_subsystem_pkg::bus_addr_w-1:0] m_slot_addr;
	logic [cpu_subsystem_pkg::bus_addr_w-1:0] s_slot_addr;
	logic [cpu_subsystem_pkg::data_w-1:0] m_slot_data;
	logic [cpu_subsystem_pkg::data_w-1:0] s_slot_data;

	assign m_issue = m_full && !phase;
	assign s_issue = s_full && phase;

	// A slot being emptied this cycle can take a new request
	assign m_accept = m_req && (!m_full || m_issue);
	assign s_accept = s_req && (!s_full || s_issue);

	////////////////////////////////////////////////////////////////////////////
	// Slot control and phase
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			phase <= 1'b0;
			m_full <= 1'b0;
			s_full <= 1'b0;
			overrun <= 1'b0;
		end else begin
			phase <= ~phase;
			if (m_accept) begin
				m_full <= 1'b1;
			end else if (m_issue) begin
				m_full <= 1'b0;
			end
			if (s_accept) begin
				s_full <= 1'b1;
			end else if (s_issue) begin
				s_full <= 1'b0;
			end
			// Dropped request, sticky until reset
			if ((m_req && !m_accept) || (s_req && !s_accept)) begin
				overrun <= 1'b1;
			end
		end
	end

	// Slot payloads
	always_ff @(posedge clk_6m) begin
		if (m_accept) begin
			m_slot_region <= m_region;
			m_slot_addr <= m_addr;
			m_slot_data <= m_data;
		end
		if (s_accept) begin
			s_slot_region <= s_region;
			s_slot_addr <= s_addr;
			s_slot_data <= s_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Shared video bus
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		bus_we = m_issue || s_issue;
		bus_from_sub = phase;
		if (phase) begin
			bus_region = s_issue ? s_slot_region : cpu_subsystem_pkg::region_none;
			bus_addr = s_slot_addr;
			bus_data = s_slot_data;
		end else begin
			bus_region = m_issue ? m_slot_region : cpu_subsystem_pkg::region_none;
			bus_addr = m_slot_addr;
			bus_data = m_slot_data;
		end
	end

endmodule

`default_nettype wire

//--- video_latch_bank.sv
`timescale 1ns/1ps
`default_nettype none

module video_latch_bank (
	input  wire                                            clk_6m,
	input  wire                                            reset,
	input  wire                                            bus_we,
	input  wire cpu_subsystem_pkg::region_t                bus_region,
	input  wire [cpu_subsystem_pkg::bus_addr_w-1:0]        bus_addr,
	input  wire [cpu_subsystem_pkg::data_w-1:0]            bus_data,
	input  wire                                            bus_from_sub,
	output logic                                           scroll0_n,
	output logic                                           scroll1_n,
	output logic                                           object_n,
	output logic                                           backcolor_n,
	output logic                                           latch0_n,
	output logic                                           latch1_n,
	output logic [cpu_subsystem_pkg::data_w-1:0]           scroll0_data,
	output logic [cpu_subsystem_pkg::data_w-1:0]           scroll1_data,
	output logic [cpu_subsystem_pkg::data_w-1:0]           backcolor_md,
	output logic                                           bank,
	output logic [cpu_subsystem_pkg::bus_addr_w-1:0]       obj_addr
);

	logic hit_scroll0;
	logic hit_scroll1;
	logic hit_object;
	logic hit_latch0;
	logic hit_latch1;
	logic hit_backcolor;
	logic hit_bank;

	// Backcolor and bank are driven by the sub CPU only
	always_comb begin
		hit_scroll0 = bus_we && (bus_region == cpu_subsystem_pkg::region_scroll0);
		hit_scroll1 = bus_we && (bus_region == cpu_subsystem_pkg::region_scroll1);
		hit_object = bus_we && (bus_region == cpu_subsystem_pkg::region_object);
		hit_latch0 = bus_we && (bus_region == cpu_subsystem_pkg::region_latch0);
		hit_latch1 = bus_we && (bus_region == cpu_subsystem_pkg::region_latch1);
		hit_backcolor = bus_we && bus_from_sub
			&& (bus_region == cpu_subsystem_pkg::region_backcolor);
		hit_bank = bus_we && bus_from_sub && (bus_region == cpu_subsystem_pkg::region_bank);
	end

	////////////////////////////////////////////////////////////////////////////
	// Strobes and latches
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			scroll0_n <= 1'b1;
			scroll1_n <= 1'b1;
			object_n <= 1'b1;
			backcolor_n <= 1'b1;
			latch0_n <= 1'b1;
			latch1_n <= 1'b1;
			scroll0_data <= cpu_subsystem_pkg::latch_reset;
			scroll1_data <= cpu_subsystem_pkg::latch_reset;
			backcolor_md <= cpu_subsystem_pkg::latch_reset;
			bank <= cpu_subsystem_pkg::bank_reset;
			obj_addr <= '0;
		end else begin
			scroll0_n <= ~hit_scroll0;
			scroll1_n <= ~hit_scroll1;
			object_n <= ~hit_object;
			backcolor_n <= ~hit_backcolor;
			latch0_n <= ~hit_latch0;
			latch1_n <= ~hit_latch1;
			if (hit_scroll0) begin
				scroll0_data <= bus_data;
			end
			if (hit_scroll1) begin
				scroll1_data <= bus_data;
			end
			if (hit_object) begin
				obj_addr <= bus_addr;
			end
			if (hit_backcolor) begin
				backcolor_md <= bus_data;
			end
			if (hit_bank) begin
				bank <= bus_data[0];
			end
		end
	end

endmodule

`default_nettype wire

//--- cpu_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_subsystem (
	input  wire                                            clk_6m,
	input  wire                                            reset,
	input  wire [cpu_subsystem_pkg::cpu_addr_w-1:0]        m_addr,
	input  wire [cpu_subsystem_pkg::data_w-1:0]            m_wdata,
	input  wire                                            m_wr,
	input  wire [cpu_subsystem_pkg::cpu_addr_w-1:0]        s_addr,
	input  wire [cpu_subsystem_pkg::data_w-1:0]            s_wdata,
	input  wire                                            s_wr,
	input  wire                                            vblank_n,
	output wire                                            scroll0_n,
	output wire                                            scroll1_n,
	output wire                                            object_n,
	output wire                                            backcolor_n,
	output wire                                            latch0_n,
	output wire                                            latch1_n,
	output wire [cpu_subsystem_pkg::data_w-1:0]            scroll0_data,
	output wire [cpu_subsystem_pkg::data_w-1:0]            scroll1_data,
	output wire [cpu_subsystem_pkg::data_w-1:0]            backcolor_md,
	output wire                                            bank,
	output wire [cpu_subsystem_pkg::bus_addr_w-1:0]        obj_addr,
	output wire                                            m_irq_n,
	output wire                                            s_irq_n,
	output wire [cpu_subsystem_pkg::bus_addr_w-1:0]        bus_a,
	output wire                                            bus_we,
	output wire                                            overrun
);

	// Decoder requests
	wire m_req;
	wire cpu_subsystem_pkg::region_t m_req_region;
	wire [cpu_subsystem_pkg::bus_addr_w-1:0] m_req_addr;
	wire [cpu_subsystem_pkg::data_w-1:0] m_req_data;
	wire s_req;
	wire cpu_subsystem_pkg::region_t s_req_region;
	wire [cpu_subsystem_pkg::bus_addr_w-1:0] s_req_addr;
	wire [cpu_subsystem_pkg::data_w-1:0] s_req_data;

	// Shared video bus
	wire cpu_subsystem_pkg::region_t bus_region;
	wire [cpu_subsystem_pkg::data_w-1:0] bus_data;
	wire bus_from_sub;

	master_decoder master_decoder_i (
		.clk_6m(clk_6m),
		.reset(reset),
		.addr(m_addr),
		.wdata(m_wdata),
		.wr(m_wr),
		.vblank_n(vblank_n),
		.req(m_req),
		.req_region(m_req_region),
		.req_addr(m_req_addr),
		.req_data(m_req_data),
		.irq_n(m_irq_n)
	);

	sub_decoder sub_decoder_i (
		.clk_6m(clk_6m),
		.reset(reset),
		.addr(s_addr),
		.wdata(s_wdata),
		.wr(s_wr),
		.vblank_n(vblank_n),
		.req(s_req),
		.req_region(s_req_region),
		.req_addr(s_req_addr),
		.req_data(s_req_data),
		.irq_n(s_irq_n)
	);

	bus_mux bus_mux_i (
		.clk_6m(clk_6m),
		.reset(reset),
		.m_req(m_req),
		.m_region(m_req_region),
		.m_addr(m_req_addr),
		.m_data(m_req_data),
		.s_req(s_req),
		.s_region(s_req_region),
		.s_addr(s_req_addr),
		.s_data(s_req_data),
		.bus_we(bus_we),
		.bus_region(bus_region),
		.bus_addr(bus_a),
		.bus_data(bus_data),
		.bus_from_sub(bus_from_sub),
		.overrun(overrun)
	);

	video_latch_bank video_latch_bank_i (
		.clk_6m(clk_6m),
		.reset(reset),
		.bus_we(bus_we),
		.bus_region(bus_region),
		.bus_addr(bus_a),
		.bus_data(bus_data),
		.bus_from_sub(bus_from_sub),
		.scroll0_n(scroll0_n),
		.scroll1_n(scroll1_n),
		.object_n(object_n),
		.backcolor_n(backcolor_n),
		.latch0_n(latch0_n),
		.latch1_n(latch1_n),
		.scroll0_data(scroll0_data),
		.scroll1_data(scroll1_data),
		.backcolor_md(backcolor_md),
		.bank(bank),
		.obj_addr(obj_addr)
	);

endmodule

`default_nettype wire

//--- tb_cpu_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_subsystem;

	logic clk_6m;
	logic reset;
	logic [15:0] m_addr;
	logic [7:0] m_wdata;
	logic m_wr;
	logic [15:0] s_addr;
	logic [7:0] s_wdata;
	logic s_wr;
	logic vblank_n;

	wire scroll0_n;
	wire scroll1_n;
	wire object_n;
	wire backcolor_n;
	wire latch0_n;
	wire latch1_n;
	wire [7:0] scroll0_data;
	wire [7:0] scroll1_data;
	wire [7:0] backcolor_md;
	wire bank;
	wire [12:0] obj_addr;
	wire m_irq_n;
	wire s_irq_n;
	wire [12:0] bus_a;
	wire bus_we;
	wire overrun;

	int unsigned cyc;
	integer seed;
	int value_errors;
	int timeout_errors;
	int fd;
	string line;

	// Current vector from the data file
	logic [7:0] v_op;
	logic [15:0] v_addr;
	logic [7:0] v_data;
	int v_gap;
	int v_region;
	logic [7:0] v_expect;

	// Reference model of the latch bank and interrupts
	logic [7:0] exp_scroll0;
	logic [7:0] exp_scroll1;
	logic [7:0] exp_backcolor;
	logic exp_bank;
	logic [12:0] exp_obj_addr;
	logic exp_m_irq_n;
	logic exp_s_irq_n;
	logic exp_overrun;

	cpu_subsystem dut_i (
		.clk_6m(clk_6m),
		.reset(reset),
		.m_addr(m_addr),
		.m_wdata(m_wdata),
		.m_wr(m_wr),
		.s_addr(s_addr),
		.s_wdata(s_wdata),
		.s_wr(s_wr),
		.vblank_n(vblank_n),
		.scroll0_n(scroll0_n),
		.scroll1_n(scroll1_n),
		.object_n(object_n),
		.backcolor_n(backcolor_n),
		.latch0_n(latch0_n),
		.latch1_n(latch1_n),
		.scroll0_data(scroll0_data),
		.scroll1_data(scroll1_data),
		.backcolor_md(backcolor_md),
		.bank(bank),
		.obj_addr(obj_addr),
		.m_irq_n(m_irq_n),
		.s_irq_n(s_irq_n),
		.bus_a(bus_a),
		.bus_we(bus_we),
		.overrun(overrun)
	);

	always #10 clk_6m = ~clk_6m;

	// Edge count since reset with the bus phase in its low bit
	always @(posedge clk_6m) begin
		if (reset) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory maps and strobe lookup
	////////////////////////////////////////////////////////////////////////////

	function automatic cpu_subsystem_pkg::region_t master_region(input logic [15:0] a);
		case (a[15:11])
			cpu_subsystem_pkg::master_page_scroll0: return cpu_subsystem_pkg::region_scroll0;
			cpu_subsystem_pkg::master_page_scroll1: return cpu_subsystem_pkg::region_scroll1;
			cpu_subsystem_pkg::master_page_object: return cpu_subsystem_pkg::region_object;
			cpu_subsystem_pkg::master_page_latch0: return cpu_subsystem_pkg::region_latch0;
			cpu_subsystem_pkg::master_page_latch1: return cpu_subsystem_pkg::region_latch1;
			cpu_subsystem_pkg::master_page_irq_ack: return cpu_subsystem_pkg::region_irq_ack;
			default: return cpu_subsystem_pkg::region_none;
		endcase
	endfunction

	function automatic cpu_subsystem_pkg::region_t sub_region(input logic [15:0] a);
		case (a[15:10])
			cpu_subsystem_pkg::sub_page_scroll0: return cpu_subsystem_pkg::region_scroll0;
			cpu_subsystem_pkg::sub_page_scroll1: return cpu_subsystem_pkg::region_scroll1;
			cpu_subsystem_pkg::sub_page_object: return cpu_subsystem_pkg::region_object;
			cpu_subsystem_pkg::sub_page_backcolor: return cpu_subsystem_pkg::region_backcolor;
			cpu_subsystem_pkg::sub_page_bank: return cpu_subsystem_pkg::region_bank;
			cpu_subsystem_pkg::sub_page_irq_ack: return cpu_subsystem_pkg::region_irq_ack;
			default: return cpu_subsystem_pkg::region_none;
		endcase
	endfunction

	function automatic logic strobe_of(input cpu_subsystem_pkg::region_t r);
		case (r)
			cpu_subsystem_pkg::region_scroll0: return scroll0_n;
			cpu_subsystem_pkg::region_scroll1: return scroll1_n;
			cpu_subsystem_pkg::region_object: return object_n;
			cpu_subsystem_pkg::region_latch0: return latch0_n;
			cpu_subsystem_pkg::region_latch1: return latch1_n;
			cpu_subsystem_pkg::region_backcolor: return backcolor_n;
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic any_strobe_low();
		return !(scroll0_n && scroll1_n && object_n && backcolor_n && latch0_n && latch1_n);
	endfunction

	// Value the data file expects for a region after the write
	function automatic logic [7:0] region_value(input cpu_subsystem_pkg::region_t r,
			input logic [7:0] d);
		case (r)
			cpu_subsystem_pkg::region_scroll0: return exp_scroll0;
			cpu_subsystem_pkg::region_scroll1: return exp_scroll1;
			cpu_subsystem_pkg::region_object: return exp_obj_addr[7:0];
			cpu_subsystem_pkg::region_latch0: return d;
			cpu_subsystem_pkg::region_latch1: return d;
			cpu_subsystem_pkg::region_backcolor: return exp_backcolor;
			cpu_subsystem_pkg::region_bank: return {7'b0, exp_bank};
			cpu_subsystem_pkg::region_irq_ack: return {6'b0, exp_m_irq_n, exp_s_irq_n};
			default: return 8'h00;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_region(input cpu_subsystem_pkg::region_t got,
			input cpu_subsystem_pkg::region_t exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0t ns: %s is %s, expected %s", $time, what,
				got.name(), exp.name());
		end
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_model();
		check_byte(scroll0_data, exp_scroll0, "scroll0_data");
		check_byte(scroll1_data, exp_scroll1, "scroll1_data");
		check_byte(backcolor_md, exp_backcolor, "backcolor_md");
		check_byte(obj_addr[7:0], exp_obj_addr[7:0], "obj_addr low");
		check_byte({3'b0, obj_addr[12:8]}, {3'b0, exp_obj_addr[12:8]}, "obj_addr high");
		check_bit(bank, exp_bank, "bank");
		check_bit(m_irq_n, exp_m_irq_n, "m_irq_n");
		check_bit(s_irq_n, exp_s_irq_n, "s_irq_n");
		check_bit(overrun, exp_overrun, "overrun");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Drive point 2 ns after the rising edge
	task automatic step();
		@(posedge clk_6m);
		#2;
	endtask

	task automatic idle_gap(input int g);
		int extra;
		extra = $unsigned($random(seed)) % 4;
		repeat (g + extra) step();
	endtask

	task automatic align_phase(input logic parity);
		while (cyc[0] != parity) step();
	endtask

	task automatic apply_write(input logic is_sub, input cpu_subsystem_pkg::region_t r,
			input logic [15:0] a, input logic [7:0] d);
		case (r)
			cpu_subsystem_pkg::region_scroll0: exp_scroll0 = d;
			cpu_subsystem_pkg::region_scroll1: exp_scroll1 = d;
			cpu_subsystem_pkg::region_object: exp_obj_addr = a[12:0];
			cpu_subsystem_pkg::region_backcolor: exp_backcolor = d;
			cpu_subsystem_pkg::region_bank: exp_bank = d[0];
			cpu_subsystem_pkg::region_irq_ack: begin
				if (is_sub) begin
					exp_s_irq_n = 1'b1;
				end else begin
					exp_m_irq_n = 1'b1;
				end
			end
			default: ;
		endcase
	endtask

	task automatic wait_strobe(input cpu_subsystem_pkg::region_t r);
		int n;
		n = 0;
		while (strobe_of(r) && n < 20) begin
			step();
			n++;
		end
		if (strobe_of(r)) begin
			timeout_errors++;
			$display("Timeout at %0t ns: no %s strobe within 20 cycles", $time, r.name());
		end
	endtask

	task automatic wait_bus_write();
		int n;
		n = 0;
		while (!bus_we && n < 20) begin
			step();
			n++;
		end
		if (!bus_we) begin
			timeout_errors++;
			$display("Timeout at %0t ns: no video bus write within 20 cycles", $time);
		end
	endtask

	task automatic wait_irq_release(input logic is_sub);
		int n;
		n = 0;
		while (!(is_sub ? s_irq_n : m_irq_n) && n < 20) begin
			step();
			n++;
		end
		if (!(is_sub ? s_irq_n : m_irq_n)) begin
			timeout_errors++;
			$display("Timeout at %0t ns: interrupt was not released by the ack write", $time);
		end
	endtask

	task automatic no_strobe_window();
		int n;
		for (n = 0; n < 10; n++) begin
			step();
			if (any_strobe_low()) begin
				value_errors++;
				$display("** Error at %0t ns: unexpected strobe on the video bus", $time);
			end
		end
	endtask

	task automatic do_reset();
		reset = 1'b1;
		repeat (10) step();
		reset = 1'b0;
		exp_scroll0 = 8'h00;
		exp_scroll1 = 8'h00;
		exp_backcolor = 8'h00;
		exp_bank = 1'b0;
		exp_obj_addr = '0;
		exp_m_irq_n = 1'b1;
		exp_s_irq_n = 1'b1;
		exp_overrun = 1'b0;
		check_bit(any_strobe_low(), 1'b0, "strobe after reset");
		check_bit(bus_we, 1'b0, "bus_we after reset");
		check_model();
	endtask

	task automatic drive_cpu(input logic is_sub, input logic [15:0] a, input logic [7:0] d);
		if (is_sub) begin
			s_addr = a;
			s_wdata = d;
			s_wr = 1'b1;
		end else begin
			m_addr = a;
			m_wdata = d;
			m_wr = 1'b1;
		end
	endtask

	task automatic read_vector(output logic found);
		int rc;
		int n;
		found = 1'b0;
		while (!found && !$feof(fd)) begin
			n = 0;
			rc = $fgets(line, fd);
			if (rc > 0) begin
				n = $sscanf(line, "%c %h %h %d %d %h", v_op, v_addr, v_data, v_gap,
					v_region, v_expect);
			end
			if (n == 6) begin
				found = 1'b1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Operations from the data file
	////////////////////////////////////////////////////////////////////////////

	task automatic run_single(input logic is_sub);
		cpu_subsystem_pkg::region_t r;
		r = is_sub ? sub_region(v_addr) : master_region(v_addr);
		check_region(r, cpu_subsystem_pkg::region_t'(v_region[3:0]), "decoded region");
		drive_cpu(is_sub, v_addr, v_data);
		step();
		m_wr = 1'b0;
		s_wr = 1'b0;
		if (r == cpu_subsystem_pkg::region_none) begin
			no_strobe_window();
		end else if (r == cpu_subsystem_pkg::region_irq_ack) begin
			wait_irq_release(is_sub);
			apply_write(is_sub, r, v_addr, v_data);
		end else begin
			wait_bus_write();
			check_byte(bus_a[7:0], v_addr[7:0], "bus_a low");
			check_byte({3'b0, bus_a[12:8]}, {3'b0, v_addr[12:8]}, "bus_a high");
			if (r == cpu_subsystem_pkg::region_bank) begin
				// Bank has no strobe of its own
				step();
				check_bit(any_strobe_low(), 1'b0, "strobe on bank write");
				apply_write(is_sub, r, v_addr, v_data);
				check_model();
			end else begin
				wait_strobe(r);
				apply_write(is_sub, r, v_addr, v_data);
				check_model();
				step();
				check_bit(strobe_of(r), 1'b1, "strobe after one cycle");
			end
		end
		check_byte(region_value(r, v_data), v_expect, "file expected value");
		check_model();
	endtask

	// Master and sub in one cycle with the master in phase 0
	task automatic run_pair();
		cpu_subsystem_pkg::region_t rm;
		cpu_subsystem_pkg::region_t rs;
		logic [15:0] ma;
		logic [7:0] md;
		logic found;
		rm = master_region(v_addr);
		check_region(rm, cpu_subsystem_pkg::region_t'(v_region[3:0]), "master region");
		check_byte(v_data, v_expect, "file expected value");
		ma = v_addr;
		md = v_data;
		read_vector(found);
		check_bit(found, 1'b1, "sub partner line present");
		rs = sub_region(v_addr);
		check_region(rs, cpu_subsystem_pkg::region_t'(v_region[3:0]), "sub region");
		align_phase(1'b0);
		drive_cpu(1'b0, ma, md);
		drive_cpu(1'b1, v_addr, v_data);
		step();
		m_wr = 1'b0;
		s_wr = 1'b0;
		wait_strobe(rm);
		apply_write(1'b0, rm, ma, md);
		check_model();
		step();
		check_bit(strobe_of(rs), 1'b0, "sub strobe right after master");
		apply_write(1'b1, rs, v_addr, v_data);
		check_byte(region_value(rs, v_data), v_expect, "file expected value");
		check_model();
	endtask

	// Second request hits a full slot in phase 1
	task automatic run_overrun();
		cpu_subsystem_pkg::region_t r;
		r = master_region(v_addr);
		check_region(r, cpu_subsystem_pkg::region_t'(v_region[3:0]), "decoded region");
		align_phase(1'b1);
		drive_cpu(1'b0, v_addr, v_data);
		step();
		m_wdata = v_data + 8'h01;
		step();
		m_wr = 1'b0;
		wait_strobe(r);
		apply_write(1'b0, r, v_addr, v_data);
		exp_overrun = 1'b1;
		check_byte({7'b0, exp_overrun}, v_expect, "file expected value");
		check_model();
		no_strobe_window();
		check_model();
	endtask

	task automatic run_vblank();
		int n;
		vblank_n = 1'b0;
		n = 0;
		while ((m_irq_n || s_irq_n) && n < 20) begin
			step();
			n++;
		end
		if (m_irq_n || s_irq_n) begin
			timeout_errors++;
			$display("Timeout at %0t ns: vblank edge raised no interrupt", $time);
		end
		vblank_n = 1'b1;
		exp_m_irq_n = 1'b0;
		exp_s_irq_n = 1'b0;
		step();
		check_byte({6'b0, exp_m_irq_n, exp_s_irq_n}, v_expect, "file expected value");
		check_model();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic found;
		clk_6m = 1'b0;
		reset = 1'b1;
		m_addr = '0;
		m_wdata = '0;
		m_wr = 1'b0;
		s_addr = '0;
		s_wdata = '0;
		s_wr = 1'b0;
		vblank_n = 1'b1;
		seed = 32'h29e3;
		value_errors = 0;
		timeout_errors = 0;
		fd = $fopen("cpu_subsystem_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file cpu_subsystem_input.txt");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			do_reset();
			read_vector(found);
			while (found) begin
				case (v_op)
					"m": run_single(1'b0);
					"s": run_single(1'b1);
					"p": run_pair();
					"o": run_overrun();
					"v": run_vblank();
					"r": do_reset();
					default: begin
						value_errors++;
						$display("Unknown operation in stimulus line: %s", line);
					end
				endcase
				idle_gap(v_gap);
				read_vector(found);
			end
			$fclose(fd);
			$display("Errors: value %0d, timeout %0d", value_errors, timeout_errors);
			if (value_errors == 0 && timeout_errors == 0) begin
				$display("STATUS: PASS");
			end else begin
				$display("STATUS: FAIL");
			end
			$finish;
		end
	end

	// Whole-run limit
	initial begin
		#2000000;
		$display("Simulation ran past its time limit");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- cpu_subsystem_input.txt
# op addr data gap region expect  (op m/s write, p pair with next s line, o overrun, v vblank, r reset)
# region is the decimal enum value, expect is hex: register value, irq_n pair or overrun bit
r 0000 00 2 0 00
m 2000 5a 2 1 5a
m 2834 c3 2 2 c3
m 3123 77 2 3 23
m 4000 11 2 4 11
m 4800 22 2 5 22
m 1000 99 2 0 00
s 4000 a5 2 6 a5
s 4401 3d 2 7 01
m 4000 66 2 4 66
m 4401 67 2 4 67
s 2000 81 2 1 81
s 2bff 42 2 2 42
s 3155 10 2 3 55
s 0400 ee 2 0 00
p 2010 aa 2 1 aa
s 2020 bb 2 1 bb
v 0000 00 2 0 00
m 8000 00 2 8 02
s 4800 00 2 8 03
v 0000 00 2 0 00
s 4800 00 2 8 01
m 8000 00 2 8 03
o 2100 12 2 1 01
m 2900 34 2 2 34
s 4401 00 2 7 00
r 0000 00 2 0 00
m 2800 56 2 2 56

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cpu_subsystem \
	-f cpu_subsystem.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
exit 1

//--- cpu_subsystem.f
cpu_subsystem_pkg.sv
master_decoder.sv
sub_decoder.sv
bus_mux.sv
video_latch_bank.sv
cpu_subsystem.sv
tb_cpu_subsystem.sv
